//--- verilog/chiplet_pkg.sv
package chiplet_pkg;

    localparam int WORD_WIDTH       = 32;
    localparam int NODE_ID_WIDTH    = 4;
    localparam int PKT_LENGTH_WIDTH = 5;

    // length field sits at the bottom of the header word.
    localparam int HDR_LEN_LSB = 0;

    typedef logic [WORD_WIDTH-1:0]       word_t;
    typedef logic [NODE_ID_WIDTH-1:0]    node_id_t;

    // last flit index, header counted as index zero.
    typedef logic [PKT_LENGTH_WIDTH-1:0] pkt_len_t;

endpackage

//--- verilog/pkt_buffer.sv
`timescale 1ns/1ps

module pkt_buffer import chiplet_pkg::*; #(
    parameter int BUF_AWIDTH = 8
) (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  wr_en,
    input  logic [BUF_AWIDTH-1:0] wr_addr,
    input  word_t                 wr_data,
    input  logic                  rd_en,
    input  logic [BUF_AWIDTH-1:0] rd_addr,
    output word_t                 rd_data
);

    localparam int DEPTH = 1 << BUF_AWIDTH;

    word_t mem [DEPTH];

    // host side write.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, old word wins on a same-address write.
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- verilog/msg_table.sv
`timescale 1ns/1ps

module msg_table #(
    parameter int NUM_MSGS   = 4,
    parameter int BUF_AWIDTH = 8,
    localparam int ID_W      = (NUM_MSGS > 1) ? $clog2(NUM_MSGS) : 1
) (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  post_valid,
    output logic                  post_ready,
    input  logic [ID_W-1:0]       post_id,
    input  logic [BUF_AWIDTH-1:0] post_addr,
    output logic                  pend_valid,
    output logic [ID_W-1:0]       pend_id,
    output logic [BUF_AWIDTH-1:0] pend_addr,
    input  logic                  done,
    input  logic [ID_W-1:0]       done_id
);

    logic [BUF_AWIDTH-1:0] start_addr [NUM_MSGS];
    logic [NUM_MSGS-1:0]   pending;
    logic [NUM_MSGS-1:0]   cand;
    logic                  busy;      // fsm is sending busy_id.
    logic [ID_W-1:0]       busy_id;
    logic                  post_fire;

    assign post_ready = !pending[post_id];
    assign post_fire  = post_valid && post_ready;

    always_ff @(posedge clk) begin
        if (post_fire) begin
            start_addr[post_id] <= post_addr;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            pending <= '0;
        end else begin
            if (post_fire) begin
                pending[post_id] <= 1'b1;
            end
            if (done) begin
                pending[done_id] <= 1'b0;
            end
        end
    end

    // the fsm takes any pick presented while it idles.
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            busy    <= 1'b0;
            busy_id <= '0;
        end else if (done) begin
            busy <= 1'b0;
        end else if (pend_valid && !busy) begin
            busy    <= 1'b1;
            busy_id <= pend_id;
        end
    end

    // lowest pending id, skipping the one in service.
    always_comb begin
        cand = pending;
        if (busy) begin
            cand[busy_id] = 1'b0;
        end
        pend_valid = |cand;
        pend_id    = '0;
        for (int i = NUM_MSGS - 1; i >= 0; i--) begin
            if (cand[i]) begin
                pend_id = ID_W'(i);
            end
        end
    end

    assign pend_addr = start_addr[pend_id];

endmodule

//--- verilog/flit_counter.sv
`timescale 1ns/1ps

module flit_counter import chiplet_pkg::*; (
    input  logic     clk,
    input  logic     n_rst,
    input  logic     cnt_clear,
    input  logic     cnt_en,
    input  pkt_len_t cnt_last,
    output pkt_len_t cnt_value,
    output logic     cnt_done
);

    pkt_len_t last_q;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            cnt_value <= '0;
            last_q    <= '0;
        end else if (cnt_clear) begin
            cnt_value <= '0;
            last_q    <= cnt_last;   // index of the final flit.
        end else if (cnt_en) begin
            cnt_value <= cnt_value + 1'b1;
        end
    end

    assign cnt_done = (cnt_value == last_q);

endmodule

//--- verilog/flit_queue.sv
`timescale 1ns/1ps

module flit_queue import chiplet_pkg::*; #(
    parameter int NUM_MSGS = 4,
    localparam int ID_W    = (NUM_MSGS > 1) ? $clog2(NUM_MSGS) : 1
) (
    input  logic            clk,
    input  logic            n_rst,
    input  logic            push_en,
    input  logic [ID_W-1:0] push_id,
    input  word_t           rd_data,
    input  node_id_t        node_id,
    output logic            room,
    output logic            flit_valid,
    input  logic            flit_ready,
    output logic [ID_W-1:0] flit_id,
    output node_id_t        flit_req,
    output word_t           flit_payload
);

    logic [ID_W-1:0] id_q  [2];
    node_id_t        req_q [2];
    word_t           pay_q [2];

    logic            push_q;     // read in flight.
    logic [ID_W-1:0] push_id_q;
    logic            wr_ptr;
    logic            rd_ptr;
    logic [1:0]      count;
    logic            pop;
    logic [2:0]      occ;

    assign pop = flit_valid && flit_ready;

    // entries held next cycle, counting the one in flight.
    assign occ  = 3'(count) + 3'(push_q) - 3'(pop);
    assign room = (occ < 3'd2);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            push_q    <= 1'b0;
            push_id_q <= '0;
        end else begin
            push_q    <= push_en;
            push_id_q <= push_id;
        end
    end

    always_ff @(posedge clk) begin
        if (push_q) begin
            id_q[wr_ptr]  <= push_id_q;
            req_q[wr_ptr] <= node_id;
            pay_q[wr_ptr] <= rd_data;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= '0;
        end else begin
            if (push_q) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            count <= occ[1:0];
        end
    end

    assign flit_valid   = (count != 2'd0);
    assign flit_id      = id_q[rd_ptr];
    assign flit_req     = req_q[rd_ptr];
    assign flit_payload = pay_q[rd_ptr];

endmodule

//--- verilog/tx_fsm.sv
`timescale 1ns/1ps

module tx_fsm import chiplet_pkg::*; #(
    parameter int NUM_MSGS   = 4,
    parameter int BUF_AWIDTH = 8,
    localparam int ID_W      = (NUM_MSGS > 1) ? $clog2(NUM_MSGS) : 1
) (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  pend_valid,
    input  logic [ID_W-1:0]       pend_id,
    input  logic [BUF_AWIDTH-1:0] pend_addr,
    output logic                  done,
    output logic [ID_W-1:0]       done_id,
    output logic                  rd_en,
    output logic [BUF_AWIDTH-1:0] rd_addr,
    input  word_t                 rd_data,
    output logic                  cnt_clear,
    output logic                  cnt_en,
    output pkt_len_t              cnt_last,
    input  pkt_len_t              cnt_value,
    input  logic                  cnt_done,
    output logic                  push_en,
    output logic [ID_W-1:0]       push_id,
    input  logic                  room
);

    typedef enum logic [1:0] {
        IDLE,
        READ_HDR,
        LOAD_LEN,
        SEND
    } state_e;

    state_e                state;
    state_e                next_state;
    logic [ID_W-1:0]       cur_id;
    logic [BUF_AWIDTH-1:0] cur_addr;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state    <= IDLE;
            cur_id   <= '0;
            cur_addr <= '0;
        end else begin
            state <= next_state;
            if (state == IDLE && pend_valid) begin
                cur_id   <= pend_id;
                cur_addr <= pend_addr;
            end
        end
    end

    // header length field, sampled in LOAD_LEN.
    assign cnt_last = rd_data[HDR_LEN_LSB +: PKT_LENGTH_WIDTH];

    assign done_id = cur_id;
    assign push_id = cur_id;

    always_comb begin
        next_state = state;
        rd_en      = 1'b0;
        rd_addr    = cur_addr;
        cnt_clear  = 1'b0;
        cnt_en     = 1'b0;
        push_en    = 1'b0;
        done       = 1'b0;

        case (state)
            IDLE: begin
                if (pend_valid) begin
                    next_state = READ_HDR;
                end
            end
            READ_HDR: begin
                rd_en      = 1'b1;
                next_state = LOAD_LEN;
            end
            LOAD_LEN: begin
                cnt_clear  = 1'b1;
                next_state = SEND;
            end
            SEND: begin
                rd_addr = cur_addr + BUF_AWIDTH'(cnt_value);
                if (room) begin
                    rd_en   = 1'b1;
                    push_en = 1'b1;   // header goes out again as flit zero.
                    cnt_en  = 1'b1;
                    if (cnt_done) begin
                        done       = 1'b1;
                        next_state = IDLE;
                    end
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

//--- verilog/chiplet_tx.sv
`timescale 1ns/1ps

module chiplet_tx import chiplet_pkg::*; #(
    parameter int NUM_MSGS   = 4,
    parameter int BUF_AWIDTH = 8,
    localparam int ID_W      = (NUM_MSGS > 1) ? $clog2(NUM_MSGS) : 1
) (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  wr_en,
    input  logic [BUF_AWIDTH-1:0] wr_addr,
    input  word_t                 wr_data,
    input  logic                  post_valid,
    output logic                  post_ready,
    input  logic [ID_W-1:0]       post_id,
    input  logic [BUF_AWIDTH-1:0] post_addr,
    input  node_id_t              node_id,
    output logic                  flit_valid,
    input  logic                  flit_ready,
    output logic [ID_W-1:0]       flit_id,
    output node_id_t              flit_req,
    output word_t                 flit_payload
);

    logic                  pend_valid;
    logic [ID_W-1:0]       pend_id;
    logic [BUF_AWIDTH-1:0] pend_addr;
    logic                  done;
    logic [ID_W-1:0]       done_id;
    logic                  rd_en;
    logic [BUF_AWIDTH-1:0] rd_addr;
    word_t                 rd_data;
    logic                  cnt_clear;
    logic                  cnt_en;
    pkt_len_t              cnt_last;
    pkt_len_t              cnt_value;
    logic                  cnt_done;
    logic                  push_en;
    logic [ID_W-1:0]       push_id;
    logic                  room;

    msg_table #(.NUM_MSGS(NUM_MSGS), .BUF_AWIDTH(BUF_AWIDTH)) u_msg_table (
        .clk(clk), .n_rst(n_rst),
        .post_valid(post_valid), .post_ready(post_ready),
        .post_id(post_id), .post_addr(post_addr),
        .pend_valid(pend_valid), .pend_id(pend_id), .pend_addr(pend_addr),
        .done(done), .done_id(done_id)
    );

    pkt_buffer #(.BUF_AWIDTH(BUF_AWIDTH)) u_pkt_buffer (
        .clk(clk), .n_rst(n_rst),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    flit_counter u_flit_counter (
        .clk(clk), .n_rst(n_rst),
        .cnt_clear(cnt_clear), .cnt_en(cnt_en), .cnt_last(cnt_last),
        .cnt_value(cnt_value), .cnt_done(cnt_done)
    );

    flit_queue #(.NUM_MSGS(NUM_MSGS)) u_flit_queue (
        .clk(clk), .n_rst(n_rst),
        .push_en(push_en), .push_id(push_id),
        .rd_data(rd_data), .node_id(node_id), .room(room),
        .flit_valid(flit_valid), .flit_ready(flit_ready),
        .flit_id(flit_id), .flit_req(flit_req), .flit_payload(flit_payload)
    );

    tx_fsm #(.NUM_MSGS(NUM_MSGS), .BUF_AWIDTH(BUF_AWIDTH)) u_tx_fsm (
        .clk(clk), .n_rst(n_rst),
        .pend_valid(pend_valid), .pend_id(pend_id), .pend_addr(pend_addr),
        .done(done), .done_id(done_id),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
        .cnt_clear(cnt_clear), .cnt_en(cnt_en), .cnt_last(cnt_last),
        .cnt_value(cnt_value), .cnt_done(cnt_done),
        .push_en(push_en), .push_id(push_id), .room(room)
    );

endmodule

//--- bench/tx_checks.svh
`ifndef TX_CHECKS_SVH
`define TX_CHECKS_SVH

int checks = 0;
int errors = 0;

task automatic fail_msg(input string what);
    checks++;
    errors++;
    $display("failure at %0t: %s.", $time, what);
endtask

task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
    end
endtask

task automatic check_node(input string name, input node_id_t exp, input node_id_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
    end
endtask

task automatic check_len(input string name, input pkt_len_t exp, input pkt_len_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("error at %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
endtask

task automatic check_id(input string name, input msg_id_t exp, input msg_id_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("error at %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("error at %0t: %s expected %b got %b", $time, name, exp, act);
    end
endtask

`endif

//--- bench/chiplet_tx_tb.sv
`timescale 1ns/1ps

module chiplet_tx_tb import chiplet_pkg::*; ();

    localparam int NUM_MSGS   = 4;
    localparam int BUF_AWIDTH = 8;
    localparam int ID_W       = $clog2(NUM_MSGS);
    localparam int REGION     = (1 << BUF_AWIDTH) / NUM_MSGS;   // words per id.

    typedef logic [ID_W-1:0] msg_id_t;

    logic                  clk;
    logic                  n_rst;
    logic                  wr_en;
    logic [BUF_AWIDTH-1:0] wr_addr;
    word_t                 wr_data;
    logic                  post_valid;
    logic                  post_ready;
    msg_id_t               post_id;
    logic [BUF_AWIDTH-1:0] post_addr;
    node_id_t              node_id;
    logic                  flit_valid;
    logic                  flit_ready;
    msg_id_t               flit_id;
    node_id_t              flit_req;
    word_t                 flit_payload;

    `include "tx_checks.svh"

    word_t    model_q [NUM_MSGS][$];   // expected words per id.
    msg_id_t  start_order [$];
    msg_id_t  rx_id = '0;
    int       rx_left = 0;
    int       posted_flits = 0;
    int       cycles = 0;
    int       test_base = 0;
    int       ready_mode = 0;         // 0 low, 1 high, 2 random.
    logic     stall_q = 1'b0;
    msg_id_t  hold_id;
    node_id_t hold_req;
    word_t    hold_pay;

    chiplet_tx #(.NUM_MSGS(NUM_MSGS), .BUF_AWIDTH(BUF_AWIDTH)) u_dut (
        .clk(clk), .n_rst(n_rst),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .post_valid(post_valid), .post_ready(post_ready),
        .post_id(post_id), .post_addr(post_addr), .node_id(node_id),
        .flit_valid(flit_valid), .flit_ready(flit_ready),
        .flit_id(flit_id), .flit_req(flit_req), .flit_payload(flit_payload)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = !clk;
    end

    initial begin
        while (cycles <= 40 * posted_flits + 2000) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with flits still outstanding", cycles);
        $display("Checks failed");
        $finish;
    end

    initial begin
        forever begin
            @(posedge clk);
            #2;
            case (ready_mode)
                0:       flit_ready = 1'b0;
                1:       flit_ready = 1'b1;
                default: flit_ready = 1'($urandom_range(0, 1));
            endcase
        end
    end

    // checks each transfer mid-cycle where all signals are settled.
    always @(negedge clk) begin
        if (n_rst && flit_valid && flit_ready) begin
            if (rx_left == 0) begin
                rx_id = flit_id;
                start_order.push_back(rx_id);
                if (model_q[rx_id].size() != 0) begin
                    rx_left = int'(model_q[rx_id][0][HDR_LEN_LSB +: PKT_LENGTH_WIDTH]) + 1;
                    check_len("header length field", pkt_len_t'(rx_left - 1),
                              flit_payload[HDR_LEN_LSB +: PKT_LENGTH_WIDTH]);
                end
            end
            check_id("flit_id", rx_id, flit_id);
            check_node("flit_req", node_id, flit_req);
            if (model_q[rx_id].size() == 0) begin
                fail_msg("a flit arrived for an id with no packet posted");
                rx_left = 0;
            end else begin
                check_word("flit_payload", model_q[rx_id].pop_front(), flit_payload);
                rx_left--;
            end
        end
    end

    // a stalled flit must hold its fields.
    always @(negedge clk) begin
        if (stall_q) begin
            if (!flit_valid) fail_msg("flit_valid fell before the flit was taken");
            check_id("held flit_id", hold_id, flit_id);
            check_node("held flit_req", hold_req, flit_req);
            check_word("held flit_payload", hold_pay, flit_payload);
        end
        stall_q  = n_rst && flit_valid && !flit_ready;
        hold_id  = flit_id;
        hold_req = flit_req;
        hold_pay = flit_payload;
    end

    function automatic logic [BUF_AWIDTH-1:0] region_base(input msg_id_t id);
        return BUF_AWIDTH'(int'(id) * REGION);
    endfunction

    function automatic int queued_words();
        int n;
        n = 0;
        for (int i = 0; i < NUM_MSGS; i++) n += model_q[i].size();
        return n;
    endfunction

    task automatic load_packet(input msg_id_t id, input int flits);
        word_t w;
        for (int i = 0; i < flits; i++) begin
            w = word_t'($urandom());
            if (i == 0) w[HDR_LEN_LSB +: PKT_LENGTH_WIDTH] = pkt_len_t'(flits - 1);
            model_q[id].push_back(w);
            wr_en   = 1'b1;
            wr_addr = region_base(id) + BUF_AWIDTH'(i);
            wr_data = w;
            @(posedge clk);
            #2;
        end
        wr_en = 1'b0;
        posted_flits += flits;
    endtask

    // waits for the id to go idle, fills its region, then posts.
    task automatic send_packet(input msg_id_t id, input int flits);
        post_id = id;
        @(negedge clk);
        while (!post_ready) @(negedge clk);
        @(posedge clk);
        #2;
        load_packet(id, flits);
        post_valid = 1'b1;
        post_addr  = region_base(id);
        @(posedge clk);
        #2;
        post_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (queued_words() != 0 || rx_left != 0) @(posedge clk);
        #2;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    function automatic msg_id_t rand_id();
        return msg_id_t'($urandom_range(0, NUM_MSGS - 1));
    endfunction

    initial begin
        void'($urandom(32'heabe_1d79));
        n_rst      = 1'b0;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        post_valid = 1'b0;
        post_id    = '0;
        post_addr  = '0;
        flit_ready = 1'b0;
        node_id    = node_id_t'($urandom());
        repeat (4) @(posedge clk);
        #2;
        n_rst = 1'b1;

        check_bit("flit_valid", 1'b0, flit_valid);
        check_bit("post_ready", 1'b1, post_ready);
        end_test("reset");

        ready_mode = 1;
        for (int i = 0; i < 6; i++) begin
            send_packet(rand_id(), int'($urandom_range(1, 32)));
            wait_drain();
        end
        end_test("single packets");

        ready_mode = 2;
        for (int i = 0; i < 8; i++) send_packet(rand_id(), int'($urandom_range(1, 32)));
        wait_drain();
        end_test("back-pressure");

        ready_mode = 0;
        @(posedge clk);
        #2;
        start_order.delete();
        send_packet(3, int'($urandom_range(3, 32)));   // long enough to stall the queue.
        send_packet(1, int'($urandom_range(1, 32)));
        send_packet(2, int'($urandom_range(1, 32)));
        ready_mode = 1;
        wait_drain();
        if (start_order.size() != 3) begin
            fail_msg("priority test did not see exactly three packets");
        end else begin
            check_id("first packet id", 3, start_order[0]);
            check_id("second packet id", 1, start_order[1]);
            check_id("third packet id", 2, start_order[2]);
        end
        end_test("priority");

        ready_mode = 0;
        @(posedge clk);
        #2;
        send_packet(0, 8);
        check_bit("post_ready while pending", 1'b0, post_ready);
        ready_mode = 1;
        wait_drain();
        check_bit("post_ready after last flit", 1'b1, post_ready);
        end_test("post_ready");

        ready_mode = 2;
        for (int i = 0; i < 40; i++) send_packet(rand_id(), int'($urandom_range(1, 32)));
        wait_drain();
        ready_mode = 1;
        repeat (40) @(posedge clk);   // a duplicate flit would show up here.
        #2;
        check_bit("flit_valid after soak", 1'b0, flit_valid);
        end_test("soak");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+bench
verilog/chiplet_pkg.sv
verilog/pkt_buffer.sv
verilog/msg_table.sv
verilog/flit_counter.sv
verilog/flit_queue.sv
verilog/tx_fsm.sv
verilog/chiplet_tx.sv
bench/chiplet_tx_tb.sv

//--- Makefile
TOP = chiplet_tx_tb

.PHONY: all lint clean

all:
	verilator --binary --timing -f flist.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "All checks passed"

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
